//--- Makefile
# Verilator build and run of the cartridge command block testbench

TOP       ?= tb_cart_top
FLIST     ?= cart_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- cart_pkg.sv
package cart_pkg;

   //////////////////////////////
   // sizes
   //////////////////////////////

   localparam int ADDR_W      = 24;
   localparam int MEM_AW      = 12;
   localparam int BLOCK_LEN   = 512;
   localparam int WIN_W       = 10;
   localparam int FREQ_WINDOW = 4096;

   localparam logic [7:0] ECHO_BYTE = 8'hA5;

   //////////////////////////////
   // command codes
   //////////////////////////////

   // upper nibble of the command byte
   localparam logic [3:0] CMD_SET_ADDR  = 4'h0;
   localparam logic [3:0] CMD_ROM_MASK  = 4'h1;
   localparam logic [3:0] CMD_SRAM_MASK = 4'h2;
   localparam logic [3:0] CMD_MAPPER    = 4'h3;
   localparam logic [3:0] CMD_DMA       = 4'h4;
   localparam logic [3:0] CMD_WINDOW    = 4'h6;
   localparam logic [3:0] CMD_READ      = 4'h8;
   localparam logic [3:0] CMD_WRITE     = 4'h9;

   // full command bytes
   localparam logic [7:0] CMD_ECHO   = 8'hF0;
   localparam logic [7:0] CMD_STATUS = 8'hF1;
   localparam logic [7:0] CMD_FREQ   = 8'hFE;

endpackage

//--- cart_sram.sv
`timescale 1ns/100ps

module cart_sram (
   input  logic                        clk,
   input  logic                        en,
   input  logic                        we,
   input  logic [cart_pkg::MEM_AW-1:0] addr,
   input  logic [7:0]                  wdata,
   output logic [7:0]                  rdata
);

   logic [7:0] mem [2**cart_pkg::MEM_AW];

   // read returns the old contents on a write
   always_ff @(posedge clk) begin
      if (en) begin
         if (we)
            mem[addr] <= wdata;
         rdata <= mem[addr];
      end
   end

endmodule

//--- cart_top.f
cart_pkg.sv
spi_slave.sv
mcu_cmd.sv
sd_dma.sv
mem_arbiter.sv
cart_sram.sv
clk_freq_meter.sv
cart_top.sv
tb_cart_top.sv

//--- cart_top.sv
`timescale 1ns/100ps

module cart_top (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        sck,
   input  logic                        mosi,
   input  logic                        ss_n,
   output logic                        miso,
   input  logic                        sd_valid,
   input  logic [7:0]                  sd_data,
   input  logic                        snes_clk,
   output logic [3:0]                  mapper,
   output logic [cart_pkg::ADDR_W-1:0] rom_mask,
   output logic [cart_pkg::ADDR_W-1:0] saveram_mask
);

   // spi link
   logic [7:0] tx_byte;
   logic [7:0] rx_byte;
   logic [7:0] byte_cnt;
   logic       cmd_ready;
   logic       param_ready;

   // dma control
   logic [cart_pkg::ADDR_W-1:0] addr;
   logic [cart_pkg::WIN_W-1:0]  win_start;
   logic [cart_pkg::WIN_W-1:0]  win_end;
   logic                        dma_start;
   logic                        dma_partial;
   logic                        dma_busy;
   logic [31:0]                 freq;

   // memory ports
   logic                        c_req;
   logic                        c_we;
   logic [cart_pkg::ADDR_W-1:0] c_addr;
   logic [7:0]                  c_wdata;
   logic [7:0]                  c_rdata;
   logic                        c_done;
   logic                        d_req;
   logic                        d_we;
   logic [cart_pkg::ADDR_W-1:0] d_addr;
   logic [7:0]                  d_wdata;
   logic                        d_done;
   logic                        sram_en;
   logic                        sram_we;
   logic [cart_pkg::MEM_AW-1:0] sram_addr;
   logic [7:0]                  sram_wdata;
   logic [7:0]                  sram_rdata;

   spi_slave spi0 (
      .clk(clk), .arst_n(arst_n), .sck(sck), .mosi(mosi), .ss_n(ss_n),
      .miso(miso), .tx_byte(tx_byte), .cmd_ready(cmd_ready),
      .param_ready(param_ready), .rx_byte(rx_byte), .byte_cnt(byte_cnt),
      .bit_cnt()
   );

   mcu_cmd cmd0 (
      .clk(clk), .arst_n(arst_n), .cmd_ready(cmd_ready), .param_ready(param_ready),
      .rx_byte(rx_byte), .byte_cnt(byte_cnt), .tx_byte(tx_byte),
      .mapper(mapper), .rom_mask(rom_mask), .saveram_mask(saveram_mask), .addr(addr),
      .dma_start(dma_start), .dma_partial(dma_partial), .win_start(win_start),
      .win_end(win_end), .dma_busy(dma_busy), .freq(freq),
      .mreq(c_req), .mwe(c_we), .maddr(c_addr), .mwdata(c_wdata),
      .mrdata(c_rdata), .mdone(c_done)
   );

   sd_dma dma0 (
      .clk(clk), .arst_n(arst_n), .start(dma_start), .partial(dma_partial),
      .base_addr(addr), .win_start(win_start), .win_end(win_end),
      .sd_valid(sd_valid), .sd_data(sd_data), .dma_busy(dma_busy),
      .mreq(d_req), .mwe(d_we), .maddr(d_addr), .mwdata(d_wdata), .mdone(d_done)
   );

   mem_arbiter arb0 (
      .clk(clk), .arst_n(arst_n),
      .a_req(d_req), .a_we(d_we), .a_addr(d_addr), .a_wdata(d_wdata), .a_done(d_done),
      .b_req(c_req), .b_we(c_we), .b_addr(c_addr), .b_wdata(c_wdata), .b_done(c_done),
      .rdata(c_rdata), .sram_en(sram_en), .sram_we(sram_we), .sram_addr(sram_addr),
      .sram_wdata(sram_wdata), .sram_rdata(sram_rdata)
   );

   cart_sram sram0 (
      .clk(clk), .en(sram_en), .we(sram_we), .addr(sram_addr),
      .wdata(sram_wdata), .rdata(sram_rdata)
   );

   clk_freq_meter freq0 (
      .clk(clk), .arst_n(arst_n), .snes_clk(snes_clk), .freq(freq)
   );

endmodule

//--- clk_freq_meter.sv
`timescale 1ns/100ps

module clk_freq_meter (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        snes_clk,
   output logic [31:0] freq
);

   logic [2:0]  snes_sync;
   logic        snes_rise;
   logic [31:0] win_cnt;
   logic [31:0] edge_cnt;

   assign snes_rise = snes_sync[1] & ~snes_sync[2];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         snes_sync <= '0;
         win_cnt   <= '0;
         edge_cnt  <= '0;
         freq      <= '0;
      end else begin
         snes_sync <= {snes_sync[1:0], snes_clk};
         // window end publishes the count and starts over
         if (win_cnt == 32'(cart_pkg::FREQ_WINDOW - 1)) begin
            win_cnt  <= '0;
            edge_cnt <= '0;
            freq     <= edge_cnt + snes_rise;
         end else begin
            win_cnt  <= win_cnt + 32'd1;
            edge_cnt <= edge_cnt + snes_rise;
         end
      end
   end

endmodule

//--- mcu_cmd.sv
`timescale 1ns/100ps

module mcu_cmd (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        cmd_ready,
   input  logic                        param_ready,
   input  logic [7:0]                  rx_byte,
   input  logic [7:0]                  byte_cnt,
   output logic [7:0]                  tx_byte,
   output logic [3:0]                  mapper,
   output logic [cart_pkg::ADDR_W-1:0] rom_mask,
   output logic [cart_pkg::ADDR_W-1:0] saveram_mask,
   output logic [cart_pkg::ADDR_W-1:0] addr,
   output logic                        dma_start,
   output logic                        dma_partial,
   output logic [cart_pkg::WIN_W-1:0]  win_start,
   output logic [cart_pkg::WIN_W-1:0]  win_end,
   input  logic                        dma_busy,
   input  logic [31:0]                 freq,
   output logic                        mreq,
   output logic                        mwe,
   output logic [cart_pkg::ADDR_W-1:0] maddr,
   output logic [7:0]                  mwdata,
   input  logic [7:0]                  mrdata,
   input  logic                        mdone
);

   logic [7:0]  cmd;
   logic [7:0]  rd_buf;
   logic [31:0] freq_buf;

   assign maddr = addr;

   //////////////////////////////
   // command decode
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd          <= '0;
         mapper       <= '0;
         rom_mask     <= '0;
         saveram_mask <= '0;
         addr         <= '0;
         win_start    <= '0;
         win_end      <= '0;
         dma_start    <= 1'b0;
         dma_partial  <= 1'b0;
         mreq         <= 1'b0;
         mwe          <= 1'b0;
      end else begin
         dma_start <= 1'b0;
         // auto increment after every command-port access
         if (mdone) begin
            mreq <= 1'b0;
            addr <= addr + 1'b1;
         end
         if (cmd_ready) begin
            cmd <= rx_byte;
            case (rx_byte[7:4])
               cart_pkg::CMD_MAPPER: mapper <= rx_byte[3:0];
               cart_pkg::CMD_DMA: begin
                  dma_start   <= 1'b1;
                  dma_partial <= rx_byte[2];
               end
               // prefetch for reply byte 1
               cart_pkg::CMD_READ: begin
                  mreq <= 1'b1;
                  mwe  <= 1'b0;
               end
               default: ;
            endcase
         end else if (param_ready) begin
            case (cmd[7:4])
               cart_pkg::CMD_SET_ADDR:
                  case (byte_cnt)
                     8'd1: addr       <= {rx_byte, 16'h0000};
                     8'd2: addr[15:8] <= rx_byte;
                     8'd3: addr[7:0]  <= rx_byte;
                     default: ;
                  endcase
               cart_pkg::CMD_ROM_MASK:
                  case (byte_cnt)
                     8'd1: rom_mask       <= {rx_byte, 16'h0000};
                     8'd2: rom_mask[15:8] <= rx_byte;
                     8'd3: rom_mask[7:0]  <= rx_byte;
                     default: ;
                  endcase
               cart_pkg::CMD_SRAM_MASK:
                  case (byte_cnt)
                     8'd1: saveram_mask       <= {rx_byte, 16'h0000};
                     8'd2: saveram_mask[15:8] <= rx_byte;
                     8'd3: saveram_mask[7:0]  <= rx_byte;
                     default: ;
                  endcase
               // window bounds, two bytes each, high bits first
               cart_pkg::CMD_WINDOW:
                  case (byte_cnt)
                     8'd1: win_start      <= {rx_byte[1:0], 8'h00};
                     8'd2: win_start[7:0] <= rx_byte;
                     8'd3: win_end        <= {rx_byte[1:0], 8'h00};
                     8'd4: win_end[7:0]   <= rx_byte;
                     default: ;
                  endcase
               cart_pkg::CMD_READ: begin
                  mreq <= 1'b1;
                  mwe  <= 1'b0;
               end
               cart_pkg::CMD_WRITE: begin
                  mreq <= 1'b1;
                  mwe  <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (param_ready && cmd[7:4] == cart_pkg::CMD_WRITE)
         mwdata <= rx_byte;
      if (mdone && !mwe)
         rd_buf <= mrdata;
      if (cmd_ready && rx_byte == cart_pkg::CMD_FREQ)
         freq_buf <= freq;
   end

   //////////////////////////////
   // response byte
   //////////////////////////////

   always_comb begin
      if (cmd == cart_pkg::CMD_ECHO) begin
         tx_byte = cart_pkg::ECHO_BYTE;
      end else if (cmd == cart_pkg::CMD_STATUS) begin
         tx_byte = {dma_busy, 7'd0};
      end else if (cmd == cart_pkg::CMD_FREQ) begin
         case (byte_cnt)
            8'd1: tx_byte = freq_buf[31:24];
            8'd2: tx_byte = freq_buf[23:16];
            8'd3: tx_byte = freq_buf[15:8];
            8'd4: tx_byte = freq_buf[7:0];
            default: tx_byte = 8'h00;
         endcase
      end else if (cmd[7:4] == cart_pkg::CMD_READ) begin
         tx_byte = rd_buf;
      end else begin
         tx_byte = cmd;
      end
   end

   // no command-port access is still pending when a dma is kicked
   a_no_req_on_dma: assert property (@(posedge clk) disable iff (!arst_n)
      dma_start |-> !mreq);

endmodule

//--- mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        a_req,
   input  logic                        a_we,
   input  logic [cart_pkg::ADDR_W-1:0] a_addr,
   input  logic [7:0]                  a_wdata,
   output logic                        a_done,
   input  logic                        b_req,
   input  logic                        b_we,
   input  logic [cart_pkg::ADDR_W-1:0] b_addr,
   input  logic [7:0]                  b_wdata,
   output logic                        b_done,
   output logic [7:0]                  rdata,
   output logic                        sram_en,
   output logic                        sram_we,
   output logic [cart_pkg::MEM_AW-1:0] sram_addr,
   output logic [7:0]                  sram_wdata,
   input  logic [7:0]                  sram_rdata
);

   typedef enum logic [1:0] {ST_IDLE, ST_ACC, ST_DONE} state_t;

   state_t state;
   logic   sel_a;

   // dma wins, grants only from idle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         sel_a <= 1'b0;
      end else begin
         case (state)
            ST_IDLE:
               if (a_req) begin
                  sel_a <= 1'b1;
                  state <= ST_ACC;
               end else if (b_req) begin
                  sel_a <= 1'b0;
                  state <= ST_ACC;
               end
            ST_ACC:  state <= ST_DONE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign sram_en    = state == ST_ACC;
   assign sram_we    = sel_a ? a_we : b_we;
   assign sram_addr  = sel_a ? a_addr[cart_pkg::MEM_AW-1:0] : b_addr[cart_pkg::MEM_AW-1:0];
   assign sram_wdata = sel_a ? a_wdata : b_wdata;

   // registered sram read lines up with done
   assign a_done = (state == ST_DONE) && sel_a;
   assign b_done = (state == ST_DONE) && !sel_a;
   assign rdata  = sram_rdata;

   // the owner holds its request through to done
   a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
      (state == ST_ACC) |-> (sel_a ? a_req : b_req));

endmodule

//--- sd_dma.sv
`timescale 1ns/100ps

module sd_dma (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        start,
   input  logic                        partial,
   input  logic [cart_pkg::ADDR_W-1:0] base_addr,
   input  logic [cart_pkg::WIN_W-1:0]  win_start,
   input  logic [cart_pkg::WIN_W-1:0]  win_end,
   input  logic                        sd_valid,
   input  logic [7:0]                  sd_data,
   output logic                        dma_busy,
   output logic                        mreq,
   output logic                        mwe,
   output logic [cart_pkg::ADDR_W-1:0] maddr,
   output logic [7:0]                  mwdata,
   input  logic                        mdone
);

   logic                        partial_r;
   logic [cart_pkg::ADDR_W-1:0] base_r;
   logic [cart_pkg::WIN_W-1:0]  idx;
   logic                        in_win;
   logic                        last_byte;
   logic                        last_pend;
   logic                        take;

   assign in_win    = !partial_r || (idx >= win_start && idx < win_end);
   assign last_byte = idx == cart_pkg::WIN_W'(cart_pkg::BLOCK_LEN - 1);
   assign take      = dma_busy && sd_valid && !last_pend;
   // sram is the only target, every access is a write
   assign mwe       = 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dma_busy  <= 1'b0;
         partial_r <= 1'b0;
         idx       <= '0;
         mreq      <= 1'b0;
         last_pend <= 1'b0;
      end else begin
         if (mdone) begin
            mreq <= 1'b0;
            if (last_pend) begin
               dma_busy  <= 1'b0;
               last_pend <= 1'b0;
            end
         end
         if (start) begin
            dma_busy  <= 1'b1;
            partial_r <= partial;
            idx       <= '0;
            last_pend <= 1'b0;
         end else if (take) begin
            idx <= idx + 1'b1;
            if (in_win)
               mreq <= 1'b1;
            // dropped last byte ends the block at once
            if (last_byte) begin
               if (in_win)
                  last_pend <= 1'b1;
               else
                  dma_busy <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start)
         base_r <= base_addr;
      if (take && in_win) begin
         mwdata <= sd_data;
         maddr  <= base_r + {{(cart_pkg::ADDR_W - cart_pkg::WIN_W){1'b0}}, idx};
      end
   end

   // one byte of buffering, the sd side must wait for the write
   a_sd_backpressure: assert property (@(posedge clk) disable iff (!arst_n)
      (dma_busy && sd_valid) |-> !mreq);

endmodule

//--- spi_slave.sv
`timescale 1ns/100ps

module spi_slave (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       sck,
   input  logic       mosi,
   input  logic       ss_n,
   output logic       miso,
   input  logic [7:0] tx_byte,
   output logic       cmd_ready,
   output logic       param_ready,
   output logic [7:0] rx_byte,
   output logic [7:0] byte_cnt,
   output logic [2:0] bit_cnt
);

   // sck has a third stage for edge detection
   logic [2:0] sck_sync;
   logic [1:0] mosi_sync;
   logic [1:0] ss_sync;
   logic       sck_rise;
   logic       sck_fall;
   logic       frame_off;
   logic [6:0] rx_shift;
   logic [6:0] tx_shift;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sck_sync  <= '0;
         mosi_sync <= '0;
         ss_sync   <= 2'b11;
      end else begin
         sck_sync  <= {sck_sync[1:0], sck};
         mosi_sync <= {mosi_sync[0], mosi};
         ss_sync   <= {ss_sync[0], ss_n};
      end
   end

   assign sck_rise  = sck_sync[1] & ~sck_sync[2];
   assign sck_fall  = ~sck_sync[1] & sck_sync[2];
   assign frame_off = ss_sync[1];

   //////////////////////////////
   // receive and framing
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
      end else begin
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         if (frame_off) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
         end else begin
            // byte index moves on once the strobe has been seen
            if ((cmd_ready || param_ready) && byte_cnt != 8'hFF)
               byte_cnt <= byte_cnt + 8'd1;
            if (sck_rise) begin
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  cmd_ready   <= (byte_cnt == 8'd0);
                  param_ready <= (byte_cnt != 8'd0);
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= {rx_shift[5:0], mosi_sync[1]};
         if (bit_cnt == 3'd7)
            rx_byte <= {rx_shift, mosi_sync[1]};
      end
   end

   //////////////////////////////
   // transmit
   //////////////////////////////

   // first falling edge of a byte loads the response, msb first
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_shift <= '0;
         miso     <= 1'b0;
      end else if (frame_off) begin
         tx_shift <= '0;
         miso     <= 1'b0;
      end else if (sck_fall) begin
         if (bit_cnt == 3'd0) begin
            miso     <= tx_byte[7];
            tx_shift <= tx_byte[6:0];
         end else begin
            miso     <= tx_shift[6];
            tx_shift <= {tx_shift[5:0], 1'b0};
         end
      end
   end

   // the master ends a frame only between whole bytes
   a_frame_on_byte: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(frame_off) |-> (bit_cnt == 3'd0));

endmodule

//--- tb_cart_top.sv
`timescale 1ns/100ps

module tb_cart_top;

   localparam int HALF_BIT  = 8;
   localparam int SD_GAP    = 8;
   localparam int FRAME_OVH = 40;

   // step kinds of the stimulus table
   localparam int K_FRAME = 0;
   localparam int K_WRITE = 1;
   localparam int K_READ  = 2;
   localparam int K_DMA   = 3;
   localparam int K_FREQ  = 4;

   logic                        clk;
   logic                        arst_n;
   logic                        sck;
   logic                        mosi;
   logic                        ss_n;
   logic                        miso;
   logic                        sd_valid;
   logic [7:0]                  sd_data;
   logic                        snes_clk;
   logic [3:0]                  mapper;
   logic [cart_pkg::ADDR_W-1:0] rom_mask;
   logic [cart_pkg::ADDR_W-1:0] saveram_mask;

   // stimulus table, one entry per step
   string       step_name [$];
   int          step_kind [$];
   logic [7:0]  step_cmd  [$];
   logic [31:0] step_prm  [$];
   int          step_nprm [$];
   int          step_cnt  [$];

   logic [7:0]                  tx_bytes [$];
   logic [7:0]                  rx_bytes [$];
   logic [7:0]                  mirror [2**cart_pkg::MEM_AW];
   logic [31:0]                 lcg_state;
   logic [cart_pkg::ADDR_W-1:0] tb_addr;
   logic [cart_pkg::WIN_W-1:0]  win_lo;
   logic [cart_pkg::WIN_W-1:0]  win_hi;
   int                          total;
   int                          cycles = 0;
   int                          cycle_limit = 0;

   cart_top dut0 (
      .clk(clk), .arst_n(arst_n), .sck(sck), .mosi(mosi), .ss_n(ss_n), .miso(miso),
      .sd_valid(sd_valid), .sd_data(sd_data), .snes_clk(snes_clk),
      .mapper(mapper), .rom_mask(rom_mask), .saveram_mask(saveram_mask)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // 10 ns console clock, kept off the clk edges
   initial begin
      snes_clk = 1'b0;
      #0.5;
      forever #5 snes_clk = ~snes_clk;
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit)
         fail_now("timeout: the test steps ran past their cycle limit");
   end

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_mask(input string name, input logic [cart_pkg::ADDR_W-1:0] exp,
                             input logic [cart_pkg::ADDR_W-1:0] act);
      if (act !== exp)
         fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_nibble(input string name, input logic [3:0] exp, input logic [3:0] act);
      if (act !== exp)
         fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   // freq allows one edge either way
   task automatic check_freq(input string name, input logic [31:0] exp, input logic [31:0] act);
      if ($isunknown(act) || act + 32'd1 < exp || act > exp + 32'd1)
         fail_now($sformatf("[FAIL] %s expected %0d +/-1 actual %0d", name, exp, act));
   endtask

   function automatic logic [7:0] lcg_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   function automatic logic [cart_pkg::MEM_AW-1:0] mem_idx(input logic [cart_pkg::ADDR_W-1:0] a);
      return a[cart_pkg::MEM_AW-1:0];
   endfunction

   function automatic int frame_cycles(input int nbytes);
      return nbytes * 16 * HALF_BIT + FRAME_OVH;
   endfunction

   function automatic int step_cycles(input int i);
      int n;
      case (step_kind[i])
         K_WRITE, K_READ: n = frame_cycles(1 + step_cnt[i]);
         K_DMA:  n = frame_cycles(1) + 2 * frame_cycles(2) + cart_pkg::BLOCK_LEN * SD_GAP + 64;
         K_FREQ: n = frame_cycles(5);
         default: n = frame_cycles(1 + step_nprm[i]);
      endcase
      return n;
   endfunction

   // reply for bytes 1 and on, except status and read
   function automatic logic [7:0] reply_of(input logic [7:0] c);
      return (c == cart_pkg::CMD_ECHO) ? cart_pkg::ECHO_BYTE : c;
   endfunction

   task automatic add_step(input string name, input int kind, input logic [7:0] cmd,
                           input logic [31:0] prm, input int nprm, input int cnt);
      step_name.push_back(name);
      step_kind.push_back(kind);
      step_cmd.push_back(cmd);
      step_prm.push_back(prm);
      step_nprm.push_back(nprm);
      step_cnt.push_back(cnt);
   endtask

   //////////////////////////////
   // spi and sd drivers
   //////////////////////////////

   // mode 0, msb first, 16 clk per bit
   task automatic spi_xfer();
      logic [7:0] rx;
      rx_bytes.delete();
      @(posedge clk);
      ss_n <= 1'b0;
      repeat (8) @(posedge clk);
      foreach (tx_bytes[i]) begin
         for (int b = 7; b >= 0; b--) begin
            @(posedge clk);
            sck  <= 1'b0;
            mosi <= tx_bytes[i][b];
            repeat (HALF_BIT - 1) @(posedge clk);
            @(negedge clk);
            rx = {rx[6:0], miso};
            @(posedge clk);
            sck <= 1'b1;
            repeat (HALF_BIT - 1) @(posedge clk);
         end
         rx_bytes.push_back(rx);
      end
      @(posedge clk);
      sck <= 1'b0;
      repeat (8) @(posedge clk);
      ss_n <= 1'b1;
      repeat (8) @(posedge clk);
   endtask

   task automatic send_sd(input logic partial);
      logic [7:0] d;
      for (int k = 0; k < cart_pkg::BLOCK_LEN; k++) begin
         d = lcg_byte();
         @(posedge clk);
         sd_valid <= 1'b1;
         sd_data  <= d;
         @(posedge clk);
         sd_valid <= 1'b0;
         repeat (SD_GAP - 2) @(posedge clk);
         if (!partial || (k >= win_lo && k < win_hi))
            mirror[mem_idx(tb_addr + cart_pkg::ADDR_W'(k))] = d;
      end
   endtask

   task automatic status_poll(input string name, input logic [7:0] exp);
      tx_bytes = '{cart_pkg::CMD_STATUS, 8'h00};
      spi_xfer();
      check_byte(name, exp, rx_bytes[1]);
   endtask

   //////////////////////////////
   // step execution
   //////////////////////////////

   task automatic apply_step(input int i);
      string       nm;
      logic [7:0]  c;
      logic [7:0]  d;
      logic [31:0] got;
      nm = step_name[i];
      c  = step_cmd[i];
      tx_bytes.delete();
      tx_bytes.push_back(c);
      case (step_kind[i])
         K_FRAME: begin
            for (int j = step_nprm[i] - 1; j >= 0; j--)
               tx_bytes.push_back(step_prm[i][8*j +: 8]);
            spi_xfer();
            for (int k = 1; k < rx_bytes.size(); k++)
               check_byte($sformatf("%s reply %0d", nm, k), reply_of(c), rx_bytes[k]);
            case (c[7:4])
               cart_pkg::CMD_SET_ADDR:  tb_addr = step_prm[i][23:0];
               cart_pkg::CMD_ROM_MASK:  check_mask(nm, step_prm[i][23:0], rom_mask);
               cart_pkg::CMD_SRAM_MASK: check_mask(nm, step_prm[i][23:0], saveram_mask);
               cart_pkg::CMD_MAPPER:    check_nibble(nm, c[3:0], mapper);
               cart_pkg::CMD_WINDOW: begin
                  win_lo = step_prm[i][25:16];
                  win_hi = step_prm[i][9:0];
               end
               default: ;
            endcase
         end
         K_WRITE: begin
            for (int k = 0; k < step_cnt[i]; k++) begin
               d = lcg_byte();
               tx_bytes.push_back(d);
               mirror[mem_idx(tb_addr + cart_pkg::ADDR_W'(k))] = d;
            end
            spi_xfer();
            for (int k = 1; k < rx_bytes.size(); k++)
               check_byte($sformatf("%s reply %0d", nm, k), c, rx_bytes[k]);
            tb_addr = tb_addr + cart_pkg::ADDR_W'(step_cnt[i]);
         end
         K_READ: begin
            repeat (step_cnt[i]) tx_bytes.push_back(8'h00);
            spi_xfer();
            for (int k = 1; k <= step_cnt[i]; k++)
               check_byte($sformatf("%s byte %0d", nm, k),
                          mirror[mem_idx(tb_addr + cart_pkg::ADDR_W'(k - 1))], rx_bytes[k]);
            // the prefetch adds one more access
            tb_addr = tb_addr + cart_pkg::ADDR_W'(step_cnt[i] + 1);
         end
         K_DMA: begin
            spi_xfer();
            fork
               send_sd(c[2]);
               begin
                  repeat (64) @(posedge clk);
                  status_poll($sformatf("%s busy", nm), 8'h80);
               end
            join
            status_poll($sformatf("%s idle", nm), 8'h00);
         end
         default: begin
            repeat (4) tx_bytes.push_back(8'h00);
            spi_xfer();
            got = {rx_bytes[1], rx_bytes[2], rx_bytes[3], rx_bytes[4]};
            check_freq(nm, 32'(cart_pkg::FREQ_WINDOW * 4 / 10), got);
         end
      endcase
   endtask

   task automatic fill_table();
      add_step("echo",          K_FRAME, cart_pkg::CMD_ECHO, 32'h0, 1, 0);
      add_step("unlisted",      K_FRAME, 8'hC3, 32'h0, 2, 0);
      add_step("rom mask",      K_FRAME, 8'h10, 32'h003F_FFFF, 3, 0);
      add_step("sram mask",     K_FRAME, 8'h20, 32'h0000_1FFF, 3, 0);
      add_step("mapper",        K_FRAME, 8'h35, 32'h0, 0, 0);
      add_step("addr write",    K_FRAME, 8'h00, 32'h0000_0100, 3, 0);
      add_step("write",         K_WRITE, 8'h90, 32'h0, 0, 32);
      add_step("addr read",     K_FRAME, 8'h00, 32'h0000_0100, 3, 0);
      add_step("read",          K_READ,  8'h80, 32'h0, 0, 32);
      add_step("addr dma",      K_FRAME, 8'h00, 32'h0000_0400, 3, 0);
      add_step("full dma",      K_DMA,   8'h40, 32'h0, 0, 0);
      add_step("addr check",    K_FRAME, 8'h00, 32'h0000_0400, 3, 0);
      add_step("full readback", K_READ,  8'h80, 32'h0, 0, cart_pkg::BLOCK_LEN);
      add_step("window",        K_FRAME, 8'h60, 32'h0040_0120, 4, 0);
      add_step("addr partial",  K_FRAME, 8'h00, 32'h0000_0400, 3, 0);
      add_step("partial dma",   K_DMA,   8'h44, 32'h0, 0, 0);
      add_step("addr check 2",  K_FRAME, 8'h00, 32'h0000_0400, 3, 0);
      add_step("part readback", K_READ,  8'h80, 32'h0, 0, cart_pkg::BLOCK_LEN);
      add_step("freq",          K_FREQ,  cart_pkg::CMD_FREQ, 32'h0, 0, 0);
   endtask

   initial begin
      arst_n    = 1'b0;
      sck       = 1'b0;
      mosi      = 1'b0;
      ss_n      = 1'b1;
      sd_valid  = 1'b0;
      sd_data   = 8'h00;
      lcg_state = 32'h9d57;
      tb_addr   = '0;
      win_lo    = '0;
      win_hi    = '0;
      fill_table();
      total = 0;
      foreach (step_kind[i])
         total += step_cycles(i);
      cycle_limit = 2 * total;
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      repeat (4) @(posedge clk);
      foreach (step_kind[i])
         apply_step(i);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
